// ==== source/vga_pkg.sv ====
package vga_pkg;

    // Pixel or line coordinate, wide enough for an 800x525 raster
    typedef logic [9:0] coord_t;

    // Two bits per channel, red in the high bits
    typedef logic [5:0] rgb_t;

    // Raster state handed from the timing stage to the pattern stage
    typedef struct packed {
        coord_t x;           // Pixel column
        coord_t y;           // Line number
        logic   active;      // Inside visible area
        logic   hsync;       // Low during line sync pulse
        logic   vsync;       // Low during frame sync pulse
        logic   frame_start; // One cycle at x=0, y=0
    } raster_t;

    // Colored pixel handed from the pattern stage to the output stage
    typedef struct packed {
        rgb_t color;         // Raw color, not yet blanked
        logic active;        // Visible area flag, carried along
        logic hsync;         // Delayed to match color
        logic vsync;         // Delayed to match color
    } pixel_t;

    // Blank color, also the pin value in reset
    localparam rgb_t RGB_BLACK = 6'b000000;

    // Pin idle values for the syncs
    localparam logic SYNC_IDLE = 1'b1;

    // Raster value used while in reset
    localparam raster_t RASTER_IDLE = '{
        x:           '0,
        y:           '0,
        active:      1'b0,
        hsync:       SYNC_IDLE,
        vsync:       SYNC_IDLE,
        frame_start: 1'b0
    };

endpackage

// ==== source/cfg_pkg.sv ====
package cfg_pkg;
    import vga_pkg::*;

    // Selects which generator drives the picture
    typedef enum logic [1:0] {
        SRC_NOISE = 2'd0,    // LFSR noise
        SRC_SOLID = 2'd1,    // Single flat color
        SRC_TEXT  = 2'd2,    // Tiled glyph
        SRC_BARS  = 2'd3     // Eight vertical bars
    } src_t;

    typedef logic [2:0]  glyph_t;   // Index into glyph ROM
    typedef logic [11:0] lfsr_t;    // Noise generator state

    // Configuration word as received over SPI, MSB first
    typedef struct packed {
        src_t       src;        // Bits 31:30
        rgb_t       solid;      // Bits 29:24
        rgb_t       text_fg;    // Bits 23:18
        rgb_t       text_bg;    // Bits 17:12
        logic [8:0] reserved;   // Bits 11:3, ignored
        glyph_t     glyph;      // Bits 2:0
    } cfg_t;

    // Solid red after reset
    localparam cfg_t CFG_RESET = '{src: SRC_SOLID, solid: 6'b110000, text_fg: '0,
                                   text_bg: '0, reserved: '0, glyph: '0};

    // Noise restarts here on every frame
    localparam lfsr_t NOISE_SEED = 12'hACE;

endpackage

// ==== source/vga_timing.sv ====
module vga_timing
    import vga_pkg::*;
#(
    parameter int H_ACTIVE = 640,   // Visible pixels per line
    parameter int H_FRONT  = 16,    // Front porch in pixels
    parameter int H_SYNC   = 96,    // Sync pulse in pixels
    parameter int H_BACK   = 48,    // Back porch in pixels
    parameter int V_ACTIVE = 480,   // Visible lines per frame
    parameter int V_FRONT  = 10,    // Front porch in lines
    parameter int V_SYNC   = 2,     // Sync pulse in lines
    parameter int V_BACK   = 33     // Back porch in lines
) (
    input  logic    clk,
    input  logic    rst_n,
    output raster_t raster
);

    localparam int H_TOTAL      = H_ACTIVE + H_FRONT + H_SYNC + H_BACK;
    localparam int V_TOTAL      = V_ACTIVE + V_FRONT + V_SYNC + V_BACK;
    localparam int H_SYNC_START = H_ACTIVE + H_FRONT;
    localparam int H_SYNC_END   = H_SYNC_START + H_SYNC;
    localparam int V_SYNC_START = V_ACTIVE + V_FRONT;
    localparam int V_SYNC_END   = V_SYNC_START + V_SYNC;

    coord_t h_cnt;      // Current pixel in line
    coord_t v_cnt;      // Current line in frame
    logic   h_last;     // Last pixel of the line
    logic   v_last;     // Last line of the frame
    logic   h_sync_on;  // Inside horizontal pulse
    logic   v_sync_on;  // Inside vertical pulse

    assign h_last    = (h_cnt == coord_t'(H_TOTAL - 1));
    assign v_last    = (v_cnt == coord_t'(V_TOTAL - 1));
    assign h_sync_on = (h_cnt >= coord_t'(H_SYNC_START)) && (h_cnt < coord_t'(H_SYNC_END));
    assign v_sync_on = (v_cnt >= coord_t'(V_SYNC_START)) && (v_cnt < coord_t'(V_SYNC_END));

    // Free running raster counters
    always_ff @(posedge clk) begin
        if (!rst_n) begin
            h_cnt <= '0;
            v_cnt <= '0;
        end else if (h_last) begin
            h_cnt <= '0;                        // Wrap to next line
            if (v_last) begin
                v_cnt <= '0;                    // Wrap to next frame
            end else begin
                v_cnt <= v_cnt + coord_t'(1);
            end
        end else begin
            h_cnt <= h_cnt + coord_t'(1);
        end
    end

    // Decoded raster, one cycle behind the counters
    always_ff @(posedge clk) begin
        if (!rst_n) begin
            raster <= RASTER_IDLE;              // Syncs idle high
        end else begin
            raster.x           <= h_cnt;
            raster.y           <= v_cnt;
            raster.active      <= (h_cnt < coord_t'(H_ACTIVE)) && (v_cnt < coord_t'(V_ACTIVE));
            raster.hsync       <= ~h_sync_on;   // Active low pulse
            raster.vsync       <= ~v_sync_on;   // Active low pulse
            raster.frame_start <= (h_cnt == '0) && (v_cnt == '0);
        end
    end

endmodule

// ==== source/spi_config.sv ====
module spi_config
    import cfg_pkg::*;
(
    input  logic clk,
    input  logic rst_n,
    input  logic sclk,         // SPI clock pin, mode 0
    input  logic mosi,         // Host data, MSB first
    input  logic ss,           // Select, active low
    input  cfg_t cur_cfg,      // Word returned to the host
    output logic miso,         // Readback data
    output logic cfg_valid,    // One clk pulse per complete word
    output cfg_t cfg_word      // Received word, valid with cfg_valid
);

    localparam logic [5:0] WORD_BITS = 6'd32;

    logic [2:0]  sclk_pipe;    // Two sync flops plus history
    logic [2:0]  ss_pipe;      // Two sync flops plus history
    logic [1:0]  mosi_pipe;    // Two sync flops, aligned with sclk_pipe[1]
    logic        sclk_rise;
    logic        sclk_fall;
    logic        ss_rise;      // End of transfer
    logic        ss_fall;      // Start of transfer
    logic        ss_low;       // Transfer in progress
    logic [31:0] shift_reg;    // Shared in and out shifter
    logic [5:0]  bit_cnt;      // Saturates at all ones

    // Pin synchronizers
    always_ff @(posedge clk) begin
        if (!rst_n) begin
            sclk_pipe <= '0;
            ss_pipe   <= '1;   // Deselected, avoids a false rise
            mosi_pipe <= '0;
        end else begin
            sclk_pipe <= {sclk_pipe[1:0], sclk};
            ss_pipe   <= {ss_pipe[1:0], ss};
            mosi_pipe <= {mosi_pipe[0], mosi};
        end
    end

    assign sclk_rise = sclk_pipe[1] & ~sclk_pipe[2];
    assign sclk_fall = ~sclk_pipe[1] & sclk_pipe[2];
    assign ss_rise   = ss_pipe[1] & ~ss_pipe[2];
    assign ss_fall   = ~ss_pipe[1] & ss_pipe[2];
    assign ss_low    = ~ss_pipe[1];

    // Load readback on select, then shift in from the bottom
    always_ff @(posedge clk) begin
        if (ss_fall) begin
            shift_reg <= cur_cfg;
        end else if (ss_low && sclk_rise) begin
            shift_reg <= {shift_reg[30:0], mosi_pipe[1]};
        end
    end

    always_ff @(posedge clk) begin
        if (!rst_n) begin
            bit_cnt   <= '0;
            miso      <= 1'b0;
            cfg_valid <= 1'b0;
        end else begin
            cfg_valid <= ss_rise && (bit_cnt == WORD_BITS);  // Short or long words dropped
            if (ss_fall) begin
                bit_cnt <= '0;
                miso    <= cur_cfg[31];    // First bit ready before first sclk rise
            end else if (ss_rise) begin
                miso    <= 1'b0;           // Idle low between transfers
            end else if (ss_low) begin
                if (sclk_rise && (bit_cnt != '1)) begin
                    bit_cnt <= bit_cnt + 6'd1;
                end
                if (sclk_fall) begin
                    miso <= shift_reg[31];   // Next bit after the shift
                end
            end
        end
    end

    // Shifter holds the full word once ss rises
    assign cfg_word = cfg_t'(shift_reg);

endmodule

// ==== source/pattern_stage.sv ====
module pattern_stage
    import vga_pkg::*;
    import cfg_pkg::*;
#(
    parameter int H_ACTIVE = 640   // Visible width for the bar width
) (
    input  logic    clk,
    input  logic    rst_n,
    input  raster_t raster,        // From timing stage
    input  logic    cfg_valid,     // New word from SPI
    input  cfg_t    cfg_word,
    output cfg_t    cur_cfg,       // Latest written word for readback
    output pixel_t  pixel          // To output stage
);

    cfg_t        pending_cfg;      // Written word waiting for frame start
    cfg_t        active_cfg;       // Word driving the picture
    cfg_t        cfg_now;          // Config seen by this pixel
    lfsr_t       lfsr;
    lfsr_t       lfsr_now;         // State for this pixel with frame start reseed
    logic        lfsr_fb;
    logic [31:0] glyph_word;       // Eight rows of four bits with row 0 at bit 0
    logic        glyph_bit;
    logic [12:0] bar_num;          // x times 8
    logic [12:0] bar_quot;
    logic [2:0]  bar_idx;
    rgb_t        noise_color;
    rgb_t        text_color;
    rgb_t        bar_color;
    rgb_t        color;

    // Config swap happens on the first pixel of the frame
    assign cfg_now = raster.frame_start ? pending_cfg : active_cfg;
    assign cur_cfg = pending_cfg;

    always_ff @(posedge clk) begin
        if (!rst_n) begin
            pending_cfg <= CFG_RESET;
            active_cfg  <= CFG_RESET;
        end else begin
            if (cfg_valid) begin
                pending_cfg <= cfg_word;
            end
            if (raster.frame_start) begin
                active_cfg <= pending_cfg;
            end
        end
    end

    // Fibonacci LFSR with taps 12 11 10 4
    assign lfsr_now    = raster.frame_start ? NOISE_SEED : lfsr;
    assign lfsr_fb     = lfsr_now[11] ^ lfsr_now[10] ^ lfsr_now[9] ^ lfsr_now[3];
    assign noise_color = lfsr_now[5:0];   // Taken before the step

    always_ff @(posedge clk) begin
        if (!rst_n) begin
            lfsr <= NOISE_SEED;
        end else if (raster.active) begin
            lfsr <= {lfsr_now[10:0], lfsr_fb};   // One step per visible pixel
        end
    end

    // Glyph ROM indexed by {row, column}
    always_comb begin
        case (cfg_now.glyph)
            3'd0:    glyph_word = 32'hF999999F;   // Hollow box
            3'd1:    glyph_word = 32'hA5A5A5A5;   // Checkerboard
            3'd2:    glyph_word = 32'h0F0F0F0F;   // Horizontal stripes
            3'd3:    glyph_word = 32'h55555555;   // Vertical stripes
            3'd4:    glyph_word = 32'h0999F996;   // Letter A
            3'd5:    glyph_word = 32'h84218421;   // Diagonal
            3'd6:    glyph_word = 32'hFFFFFFFF;   // Solid block
            default: glyph_word = 32'h066FF660;   // Plus sign
        endcase
    end

    assign glyph_bit  = glyph_word[{raster.y[2:0], raster.x[1:0]}];
    assign text_color = glyph_bit ? cfg_now.text_fg : cfg_now.text_bg;

    // Eight equal bars across the visible width
    assign bar_num   = {raster.x, 3'b000};
    assign bar_quot  = bar_num / 13'(H_ACTIVE);
    assign bar_idx   = bar_quot[2:0];
    assign bar_color = {bar_idx[2:1], bar_idx[1:0], bar_idx[0], bar_idx[2]};

    always_comb begin
        case (cfg_now.src)
            SRC_NOISE: color = noise_color;
            SRC_SOLID: color = cfg_now.solid;
            SRC_TEXT:  color = text_color;
            default:   color = bar_color;
        endcase
    end

    always_ff @(posedge clk) begin
        if (!rst_n) begin
            pixel <= '{color: RGB_BLACK, active: 1'b0, hsync: SYNC_IDLE, vsync: SYNC_IDLE};
        end else begin
            pixel.color  <= color;
            pixel.active <= raster.active;   // Timing carried along unchanged
            pixel.hsync  <= raster.hsync;
            pixel.vsync  <= raster.vsync;
        end
    end

endmodule

// ==== source/output_stage.sv ====
module output_stage
    import vga_pkg::*;
(
    input  logic   clk,
    input  logic   rst_n,
    input  pixel_t pixel,      // From pattern stage
    output logic   hsync,      // Pin, active low
    output logic   vsync,      // Pin, active low
    output rgb_t   rgb         // Pin color, black in blanking
);

    rgb_t blanked;             // Color after blanking

    // Monitors expect black outside the visible area
    assign blanked = pixel.active ? pixel.color : RGB_BLACK;

    // All pins from one register stage
    always_ff @(posedge clk) begin
        if (!rst_n) begin
            hsync <= SYNC_IDLE;
            vsync <= SYNC_IDLE;
            rgb   <= RGB_BLACK;
        end else begin
            hsync <= pixel.hsync;
            vsync <= pixel.vsync;
            rgb   <= blanked;
        end
    end

endmodule

// ==== source/vga_pattern_top.sv ====
module vga_pattern_top
    import vga_pkg::*;
    import cfg_pkg::*;
#(
    parameter int H_ACTIVE = 640,   // 640x480 at 60 Hz by default
    parameter int H_FRONT  = 16,
    parameter int H_SYNC   = 96,
    parameter int H_BACK   = 48,
    parameter int V_ACTIVE = 480,
    parameter int V_FRONT  = 10,
    parameter int V_SYNC   = 2,
    parameter int V_BACK   = 33
) (
    input  logic clk,
    input  logic rst_n,
    input  logic sclk,         // SPI clock, at most clk/8
    input  logic mosi,
    input  logic ss,           // Active low
    output logic miso,
    output logic hsync,
    output logic vsync,
    output rgb_t rgb
);

    raster_t raster;           // Stage 0 to stage 1
    pixel_t  pixel;            // Stage 1 to stage 2
    logic    cfg_valid;
    cfg_t    cfg_word;
    cfg_t    cur_cfg;          // Readback word

    vga_timing #(
        .H_ACTIVE (H_ACTIVE),
        .H_FRONT  (H_FRONT),
        .H_SYNC   (H_SYNC),
        .H_BACK   (H_BACK),
        .V_ACTIVE (V_ACTIVE),
        .V_FRONT  (V_FRONT),
        .V_SYNC   (V_SYNC),
        .V_BACK   (V_BACK)
    ) i_timing (.clk(clk), .rst_n(rst_n), .raster(raster));

    pattern_stage #(.H_ACTIVE(H_ACTIVE)) i_pattern (
        .clk(clk), .rst_n(rst_n), .raster(raster), .cfg_valid(cfg_valid),
        .cfg_word(cfg_word), .cur_cfg(cur_cfg), .pixel(pixel)
    );

    output_stage i_output (
        .clk(clk), .rst_n(rst_n), .pixel(pixel), .hsync(hsync), .vsync(vsync), .rgb(rgb)
    );

    spi_config i_spi (
        .clk(clk), .rst_n(rst_n), .sclk(sclk), .mosi(mosi), .ss(ss), .cur_cfg(cur_cfg),
        .miso(miso), .cfg_valid(cfg_valid), .cfg_word(cfg_word)
    );

endmodule

// ==== bench/tb_vga_model.svh ====
`ifndef TB_VGA_MODEL_SVH
`define TB_VGA_MODEL_SVH

// Compares one value and logs a mismatch
task automatic check_value(input logic [31:0] got, input logic [31:0] expected,
                           input string what);
    checks++;
    if (got !== expected) begin
        errors++;
        $display("CHECK FAILED at time %0t: %s, got %0h expected %0h",
                 $time, what, got, expected);
    end
endtask

// Stimulus LFSR, x^32 + x^22 + x^2 + x + 1
function automatic logic [31:0] lfsr32_next(input logic [31:0] s);
    return {s[30:0], s[31] ^ s[21] ^ s[1] ^ s[0]};
endfunction

// Glyph bitmaps, row r in bits 4r+3..4r, column c at bit 4r+c
function automatic logic [31:0] glyph_word(input logic [2:0] code);
    case (code)
        3'd0:    return 32'hF999999F;   // Hollow box
        3'd1:    return 32'hA5A5A5A5;   // Checkerboard
        3'd2:    return 32'h0F0F0F0F;   // Row stripes
        3'd3:    return 32'h55555555;   // Column stripes
        3'd4:    return 32'h0999F996;   // Letter A
        3'd5:    return 32'h84218421;   // Diagonal
        3'd6:    return 32'hFFFFFFFF;   // Solid
        default: return 32'h066FF660;   // Plus
    endcase
endfunction

// Noise for the n-th visible pixel of a frame
function automatic logic [5:0] noise_color(input int n);
    logic [11:0] s;
    s = 12'hACE;                        // Frame seed
    for (int i = 0; i < n; i++) begin
        s = {s[10:0], s[11] ^ s[10] ^ s[9] ^ s[3]};
    end
    return s[5:0];
endfunction

// Eight bars, index spread over the three channels
function automatic logic [5:0] bar_color(input int x);
    logic [2:0] idx;
    idx = 3'((x * 8) / H_ACTIVE);
    return {idx[2:1], idx[1:0], idx[0], idx[2]};
endfunction

// Expected visible color from the config word fields
function automatic logic [5:0] expected_color(input logic [31:0] cfg, input int x, input int y);
    logic [31:0] glyph;
    glyph = glyph_word(cfg[2:0]);
    case (cfg[31:30])
        2'd0:    return noise_color(y * H_ACTIVE + x);
        2'd1:    return cfg[29:24];                                  // Solid field
        2'd2:    return glyph[(y % 8) * 4 + (x % 4)] ? cfg[23:18] : cfg[17:12];
        default: return bar_color(x);
    endcase
endfunction

`endif

// ==== bench/tb_vga_pattern.sv ====
module tb_vga_pattern;

    localparam int H_ACTIVE     = 16;    // Tiny raster for simulation
    localparam int H_FRONT      = 2;
    localparam int H_SYNC       = 3;
    localparam int H_BACK       = 3;
    localparam int V_ACTIVE     = 8;
    localparam int V_FRONT      = 1;
    localparam int V_SYNC       = 2;
    localparam int V_BACK       = 1;
    localparam int H_TOTAL      = H_ACTIVE + H_FRONT + H_SYNC + H_BACK;
    localparam int V_TOTAL      = V_ACTIVE + V_FRONT + V_SYNC + V_BACK;
    localparam int H_SYNC_START = H_ACTIVE + H_FRONT;
    localparam int V_SYNC_START = V_ACTIVE + V_FRONT;
    localparam int FRAME_CYCLES = H_TOTAL * V_TOTAL;
    localparam int CLK_PERIOD   = 8;
    localparam int NUM_TESTS    = 5;
    localparam logic [31:0] RESET_WORD = {2'b01, 6'b110000, 24'h0};   // Solid red

    logic        clk, rst_n, sclk, mosi, ss, miso, hsync, vsync;
    logic [5:0]  rgb;
    int          errors, checks, failed_tests, test_base;
    logic [31:0] rng_state;
    logic [31:0] pend_cfg;      // Last word the DUT accepted
    logic [31:0] exp_cfg;       // Word in effect for the tracked frame
    logic [5:0]  exp_rgb;
    int          tx, ty;        // Tracked pin position
    int          cycle, hs_fall_at, vs_fall_at;
    logic        locked, prev_hs, prev_vs;
    event        pixel_ev;      // One per tracked pin pixel

    `include "tb_vga_model.svh"

    vga_pattern_top #(
        .H_ACTIVE(H_ACTIVE), .H_FRONT(H_FRONT), .H_SYNC(H_SYNC), .H_BACK(H_BACK),
        .V_ACTIVE(V_ACTIVE), .V_FRONT(V_FRONT), .V_SYNC(V_SYNC), .V_BACK(V_BACK)
    ) i_dut (
        .clk(clk), .rst_n(rst_n), .sclk(sclk), .mosi(mosi), .ss(ss), .miso(miso),
        .hsync(hsync), .vsync(vsync), .rgb(rgb)
    );

    always #(CLK_PERIOD / 2) clk = ~clk;

    // Takes n bits with one LFSR step each
    function automatic logic [31:0] random_bits(input int n);
        logic [31:0] v;
        v = '0;
        for (int i = 0; i < n; i++) begin
            rng_state = lfsr32_next(rng_state);
            v = {v[30:0], rng_state[0]};
        end
        return v;
    endfunction

    // Position from sync falls with sync widths checked on the way
    always @(negedge clk) begin
        cycle++;
        if (locked) begin
            tx++;
            if (tx == H_TOTAL) begin
                tx = 0;
                ty = (ty + 1) % V_TOTAL;
            end
        end
        if (prev_hs && !hsync) begin
            if (hs_fall_at >= 0) begin
                check_value(cycle - hs_fall_at, H_TOTAL, "hsync period");
            end
            hs_fall_at = cycle;
            tx = H_SYNC_START;
        end
        if (!prev_hs && hsync && hs_fall_at >= 0) begin
            check_value(cycle - hs_fall_at, H_SYNC, "hsync low width");
        end
        if (prev_vs && !vsync) begin
            if (vs_fall_at >= 0) begin
                check_value(cycle - vs_fall_at, FRAME_CYCLES, "vsync period");
            end
            vs_fall_at = cycle;
            tx = 0;                             // vsync drops at line start
            ty = V_SYNC_START;
            locked = 1'b1;
        end
        if (!prev_vs && vsync && vs_fall_at >= 0) begin
            check_value(cycle - vs_fall_at, V_SYNC * H_TOTAL, "vsync low width");
        end
        prev_hs = hsync;
        prev_vs = vsync;
        if (locked) begin
            -> pixel_ev;
        end
    end

    // Every tracked pixel with black expected in blanking
    always @(pixel_ev) begin
        if (tx == 0 && ty == 0) begin
            exp_cfg = pend_cfg;                 // New word takes effect here
        end
        if (tx < H_ACTIVE && ty < V_ACTIVE) begin
            exp_rgb = expected_color(exp_cfg, tx, ty);
        end else begin
            exp_rgb = '0;
        end
        check_value(32'(rgb), 32'(exp_rgb), $sformatf("rgb at x=%0d y=%0d", tx, ty));
    end

    task automatic wait_position(input int x, input int y);
        do begin
            @(pixel_ev);
        end while (tx != x || ty != y);
    endtask

    // Next frame start up to end of its visible area
    task automatic watch_frame();
        wait_position(0, 0);
        wait_position(0, V_ACTIVE);
    endtask

    // Mode 0 at clk/8 with miso taken before each sclk rise
    task automatic spi_transfer(input logic [31:0] word, input int nbits,
                                output logic [31:0] back);
        back = '0;
        ss = 1'b0;
        repeat (4) @(negedge clk);
        for (int i = 0; i < nbits; i++) begin
            mosi = word[31 - i];
            repeat (4) @(negedge clk);
            back = {back[30:0], miso};
            sclk = 1'b1;
            repeat (4) @(negedge clk);
            sclk = 1'b0;
        end
        repeat (4) @(negedge clk);
        ss   = 1'b1;
        mosi = 1'b0;
        repeat (4) @(negedge clk);                    // Covers sync plus edge detect
    endtask

    // Written during a frame and done well before the next one
    task automatic write_config(input logic [31:0] word);
        logic [31:0] back;
        wait_position(0, 0);
        spi_transfer(word, 32, back);
        check_value(back, pend_cfg, "SPI readback of previous word");
        pend_cfg = word;
    endtask

    // Counted between negedges so the last pixel check is in
    task automatic report_test(input int num, input string name);
        @(posedge clk);
        if (errors == test_base) begin
            $display("test %0d %s: ok", num, name);
        end else begin
            $display("test %0d %s: %0d errors", num, name, errors - test_base);
            failed_tests++;
        end
        test_base = errors;
    endtask

    initial begin
        logic [31:0] word;
        logic [31:0] back;
        clk = 1'b0;
        rst_n = 1'b0;
        sclk = 1'b0;
        mosi = 1'b0;
        ss = 1'b1;
        errors = 0;
        checks = 0;
        failed_tests = 0;
        test_base = 0;
        rng_state = 32'h2bbb3189;
        pend_cfg = RESET_WORD;
        exp_cfg = RESET_WORD;
        tx = 0;
        ty = 0;
        cycle = 0;
        hs_fall_at = -1;
        vs_fall_at = -1;
        locked = 1'b0;
        prev_hs = 1'b1;
        prev_vs = 1'b1;
        repeat (5) @(negedge clk);
        rst_n = 1'b1;

        wait_position(0, V_SYNC_START + V_SYNC);       // Past vsync rise
        report_test(1, "sync timing");

        word = random_bits(32);                        // Sent during the red frame
        word[31:30] = 2'd1;
        write_config(word);
        watch_frame();
        report_test(2, "reset red and solid color");

        for (int code = 0; code < 8; code++) begin
            word = random_bits(32);
            word[31:30] = 2'd2;
            word[2:0] = 3'(code);
            write_config(word);
        end
        watch_frame();
        report_test(3, "text glyphs");

        word = random_bits(32);
        word[31:30] = 2'd3;
        write_config(word);
        word = random_bits(32);
        word[31:30] = 2'd0;
        write_config(word);
        watch_frame();
        report_test(4, "bars and noise");

        write_config(random_bits(32));
        wait_position(0, 0);
        spi_transfer(random_bits(32), 16, back);       // Aborted so it must be dropped
        check_value(back[15:0], pend_cfg[31:16], "SPI readback in short transfer");
        write_config(random_bits(32));
        watch_frame();
        report_test(5, "SPI readback and abort");

        $display("%0d tests, %0d failed, %0d checks, %0d errors",
                 NUM_TESTS, failed_tests, checks, errors);
        if (errors == 0) begin
            $display("Test completed successfully");
        end else begin
            $display("Test failed");
        end
        $finish;
    end

    // Four frames per test
    initial begin
        #(NUM_TESTS * 4 * FRAME_CYCLES * CLK_PERIOD);
        $display("Timeout: the tests did not finish within %0d frames", NUM_TESTS * 4);
        $display("Test failed");
        $finish;
    end

endmodule

// ==== verilog.f ====
+incdir+bench
source/vga_pkg.sv
source/cfg_pkg.sv
source/vga_timing.sv
source/spi_config.sv
source/pattern_stage.sv
source/output_stage.sv
source/vga_pattern_top.sv
bench/tb_vga_pattern.sv
